// File: c51_pkg.sv
`default_nettype none

package c51_pkg;

   ////////////////////////////////////////////////////////////
   // widths and base types

   localparam int pc_w   = 10;   // 1k code space
   localparam int byte_w = 8;
   localparam int dptr_w = 16;
   localparam int grp_w  = 5;    // upper opcode bits of the rn forms

   typedef logic [pc_w-1:0]   pc_t;
   typedef logic [byte_w-1:0] byte_t;
   typedef logic [dptr_w-1:0] dptr_t;

   // rn view of an opcode byte
   typedef struct packed {
      logic [grp_w-1:0]        grp;
      logic [byte_w-grp_w-1:0] idx;
   } rn_op_t;

   typedef union packed {
      byte_t  full;
      rn_op_t rn;
   } opcode_u;

   // one issued instruction, fetch to execute
   typedef struct packed {
      opcode_u op;
      byte_t   b1;
      byte_t   b2;
      pc_t     next_pc;   // pc after the last operand byte
   } instr_t;

   typedef struct packed {
      logic taken;
      pc_t  target;
   } redirect_t;

   typedef enum logic [2:0] {
      st_fetch,
      st_decode0,
      st_decode1,
      st_decode2,
      st_execute
   } core_state_e;

   ////////////////////////////////////////////////////////////
   // opcodes, full byte

   localparam byte_t op_nop          = 8'h00;
   localparam byte_t op_inc_a        = 8'h04;
   localparam byte_t op_dec_a        = 8'h14;
   localparam byte_t op_add_a_imm    = 8'h24;
   localparam byte_t op_jc           = 8'h40;
   localparam byte_t op_jnc          = 8'h50;
   localparam byte_t op_jz           = 8'h60;
   localparam byte_t op_jnz          = 8'h70;
   localparam byte_t op_mov_a_imm    = 8'h74;
   localparam byte_t op_sjmp         = 8'h80;
   localparam byte_t op_mov_dptr_imm = 8'h90;
   localparam byte_t op_subb_a_imm   = 8'h94;
   localparam byte_t op_clr_c        = 8'hC3;
   localparam byte_t op_setb_c       = 8'hD3;
   localparam byte_t op_movx_a_dptr  = 8'hE0;
   localparam byte_t op_clr_a        = 8'hE4;
   localparam byte_t op_movx_dptr_a  = 8'hF0;
   localparam byte_t op_cpl_a        = 8'hF4;

   // rn forms, group only
   localparam logic [grp_w-1:0] op_add_a_rn   = 5'b00101;   // 28..2f
   localparam logic [grp_w-1:0] op_mov_rn_imm = 5'b01111;   // 78..7f
   localparam logic [grp_w-1:0] op_subb_a_rn  = 5'b10011;   // 98..9f
   localparam logic [grp_w-1:0] op_djnz_rn    = 5'b11011;   // d8..df
   localparam logic [grp_w-1:0] op_mov_a_rn   = 5'b11101;   // e8..ef
   localparam logic [grp_w-1:0] op_mov_rn_a   = 5'b11111;   // f8..ff

   // movx map
   localparam dptr_t TX_DATA_ADDR = 16'h0201;
   localparam dptr_t TX_STAT_ADDR = 16'h0200;

endpackage

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
   parameter int CLKS_PER_BIT = 104
) (
   input  logic           i_clk,
   input  logic           i_nrst,
   input  logic           i_rx,
   output c51_pkg::byte_t o_byte,
   output logic           o_valid
);

   localparam int               cnt_w    = $clog2(CLKS_PER_BIT);
   localparam logic [cnt_w-1:0] cnt_full = cnt_w'(CLKS_PER_BIT - 1);
   localparam logic [cnt_w-1:0] cnt_half = cnt_w'(CLKS_PER_BIT / 2 - 1);

   typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

   rx_state_e        state;
   logic [1:0]       rx_sync;
   logic [cnt_w-1:0] cnt;
   logic [2:0]       bit_cnt;
   c51_pkg::byte_t   shift;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_sync <= 2'b11;   // line idles high
         state   <= rx_idle;
         cnt     <= '0;
         bit_cnt <= '0;
         o_valid <= 1'b0;
      end else begin
         rx_sync <= {rx_sync[0], i_rx};
         o_valid <= 1'b0;
         cnt     <= cnt + 1'b1;
         case (state)
            rx_idle: begin
               cnt <= '0;
               if (!rx_sync[1]) state <= rx_start;   // start edge
            end
            rx_start: if (cnt == cnt_half) begin
               cnt     <= '0;
               bit_cnt <= '0;
               state   <= rx_sync[1] ? rx_idle : rx_data;   // glitch, back to idle
            end
            rx_data: if (cnt == cnt_full) begin
               cnt     <= '0;
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 3'd7) state <= rx_stop;
            end
            rx_stop: if (cnt == cnt_full) begin
               o_valid <= 1'b1;
               state   <= rx_idle;
            end
            default: state <= rx_idle;
         endcase
      end
   end

   // lsb arrives first
   always_ff @(posedge i_clk) begin
      if (state == rx_data && cnt == cnt_full) shift <= {rx_sync[1], shift[7:1]};
   end

   assign o_byte = shift;

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
   parameter int CLKS_PER_BIT = 104
) (
   input  logic           i_clk,
   input  logic           i_nrst,
   input  c51_pkg::byte_t i_byte,
   input  logic           i_valid,
   output logic           o_ready,
   output logic           o_busy,
   output logic           o_tx
);

   localparam int               cnt_w    = $clog2(CLKS_PER_BIT);
   localparam logic [cnt_w-1:0] cnt_full = cnt_w'(CLKS_PER_BIT - 1);

   typedef enum logic [1:0] {tx_idle, tx_start, tx_send} tx_state_e;

   tx_state_e        state;
   logic [cnt_w-1:0] cnt;
   logic [3:0]       bit_cnt;   // 8 data bits then stop
   c51_pkg::byte_t   shift;
   logic             tick;

   assign tick    = (cnt == cnt_full);
   assign o_ready = (state == tx_idle);
   assign o_busy  = (state != tx_idle);
   assign o_tx    = (state == tx_idle)  ? 1'b1 :
                    (state == tx_start) ? 1'b0 :
                                          shift[0];

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= tx_idle;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         cnt <= tick ? '0 : cnt + 1'b1;
         case (state)
            tx_idle: begin
               cnt     <= '0;
               bit_cnt <= '0;
               if (i_valid) state <= tx_start;
            end
            tx_start: if (tick) state <= tx_send;
            tx_send: if (tick) begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 4'd8) state <= tx_idle;   // stop bit done
            end
            default: state <= tx_idle;
         endcase
      end
   end

   // ones shift in behind the data, so bit 8 is the stop level
   always_ff @(posedge i_clk) begin
      if (o_ready && i_valid) begin
         shift <= i_byte;
      end else if (state == tx_send && tick) begin
         shift <= {1'b1, shift[7:1]};
      end
   end

endmodule

`default_nettype wire

// File: code_store.sv
`timescale 1ns/1ps
`default_nettype none

module code_store #(
   parameter int PROG_BYTES = 512
) (
   input  logic           i_clk,
   input  logic           i_nrst,
   input  c51_pkg::byte_t i_wr_byte,
   input  logic           i_wr_valid,
   input  c51_pkg::pc_t   i_rd_addr,
   output c51_pkg::byte_t o_rd_byte,
   output logic           o_loaded
);

   c51_pkg::byte_t mem [2**c51_pkg::pc_w];
   c51_pkg::pc_t   wr_addr;
   logic           wr_en;

   assign wr_en = i_wr_valid & ~o_loaded;   // bytes after the load are dropped

   ////////////////////////////////////////////////////////////
   // load counter

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_addr  <= '0;
         o_loaded <= 1'b0;
      end else if (wr_en) begin
         wr_addr <= wr_addr + 1'b1;
         if (wr_addr == c51_pkg::pc_t'(PROG_BYTES - 1)) o_loaded <= 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (wr_en) mem[wr_addr] <= i_wr_byte;
   end

   // async read, fetch uses it in the same cycle
   assign o_rd_byte = mem[i_rd_addr];

endmodule

`default_nettype wire

// File: fetch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_decode (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_loaded,
   input  c51_pkg::byte_t      i_code,
   output c51_pkg::pc_t        o_code_addr,
   output c51_pkg::instr_t     o_instr,
   output logic                o_valid,
   input  logic                i_ready,
   input  c51_pkg::redirect_t  i_redirect
);

   c51_pkg::core_state_e state;
   c51_pkg::pc_t         pc;
   c51_pkg::opcode_u     code_op;   // live code byte seen as an opcode
   c51_pkg::opcode_u     op_q;
   c51_pkg::byte_t       b1_q;
   c51_pkg::byte_t       b2_q;
   logic                 fire;

   // instruction length in bytes
   function automatic logic [1:0] instr_len(input c51_pkg::opcode_u op);
      logic [1:0] len;
      case (op.full)
         c51_pkg::op_mov_dptr_imm: len = 2'd3;
         c51_pkg::op_mov_a_imm,
         c51_pkg::op_add_a_imm,
         c51_pkg::op_subb_a_imm,
         c51_pkg::op_sjmp,
         c51_pkg::op_jz,
         c51_pkg::op_jnz,
         c51_pkg::op_jc,
         c51_pkg::op_jnc:          len = 2'd2;
         default:                  len = 2'd1;   // nop, and unknown runs as nop
      endcase
      if (op.rn.grp == c51_pkg::op_mov_rn_imm || op.rn.grp == c51_pkg::op_djnz_rn) begin
         len = 2'd2;
      end
      return len;
   endfunction

   assign code_op     = i_code;
   assign o_code_addr = pc;
   assign o_valid     = (state == c51_pkg::st_execute);
   assign fire        = o_valid & i_ready;
   assign o_instr     = '{op: op_q, b1: b1_q, b2: b2_q, next_pc: pc};

   ////////////////////////////////////////////////////////////
   // state sequence and pc

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= c51_pkg::st_fetch;
         pc    <= '0;
      end else begin
         case (state)
            c51_pkg::st_fetch: begin
               if (i_loaded) state <= c51_pkg::st_decode0;   // held until program is in
            end
            c51_pkg::st_decode0: begin
               pc    <= pc + 1'b1;
               state <= (instr_len(code_op) == 2'd1) ? c51_pkg::st_execute :
                                                       c51_pkg::st_decode1;
            end
            c51_pkg::st_decode1: begin
               pc    <= pc + 1'b1;
               state <= (instr_len(op_q) == 2'd3) ? c51_pkg::st_decode2 :
                                                    c51_pkg::st_execute;
            end
            c51_pkg::st_decode2: begin
               pc    <= pc + 1'b1;
               state <= c51_pkg::st_execute;
            end
            c51_pkg::st_execute: begin
               if (fire) begin
                  if (i_redirect.taken) pc <= i_redirect.target;
                  state <= c51_pkg::st_fetch;
               end
            end
            default: state <= c51_pkg::st_fetch;
         endcase
      end
   end

   // opcode and operand latches
   always_ff @(posedge i_clk) begin
      case (state)
         c51_pkg::st_decode0: op_q <= code_op;
         c51_pkg::st_decode1: b1_q <= i_code;
         c51_pkg::st_decode2: b2_q <= i_code;
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  c51_pkg::instr_t     i_instr,
   input  logic                i_valid,
   output logic                o_ready,
   output c51_pkg::redirect_t  o_redirect,
   output c51_pkg::byte_t      o_tx_byte,
   output logic                o_tx_valid,
   input  logic                i_tx_ready,
   input  logic                i_tx_busy
);

   c51_pkg::byte_t   acc;
   logic             carry;
   c51_pkg::byte_t   regs [8];
   c51_pkg::dptr_t   dptr;

   c51_pkg::opcode_u op;
   c51_pkg::byte_t   r_sel;
   c51_pkg::byte_t   r_dec;
   c51_pkg::byte_t   alu_b;
   logic [8:0]       sum;
   logic [8:0]       diff;    // bit 8 is the borrow
   logic             tx_wr;
   logic             fire;
   logic             br_cond;

   c51_pkg::byte_t   acc_nxt;
   logic             acc_we;
   logic             c_nxt;
   logic             c_we;
   c51_pkg::byte_t   r_nxt;
   logic             r_we;
   logic             dptr_we;

   assign op    = i_instr.op;
   assign r_sel = regs[op.rn.idx];
   assign r_dec = r_sel - 8'd1;   // djnz tests this value
   assign alu_b = (op.rn.grp == c51_pkg::op_add_a_rn || op.rn.grp == c51_pkg::op_subb_a_rn) ?
                  r_sel : i_instr.b1;
   assign sum   = {1'b0, acc} + {1'b0, alu_b};
   assign diff  = {1'b0, acc} - {1'b0, alu_b} - {8'd0, carry};

   ////////////////////////////////////////////////////////////
   // movx map and handshakes

   assign tx_wr      = (op.full == c51_pkg::op_movx_dptr_a) && (dptr == c51_pkg::TX_DATA_ADDR);
   assign o_ready    = ~tx_wr | i_tx_ready;   // only a tx write can stall
   assign fire       = i_valid & o_ready;
   assign o_tx_valid = i_valid & tx_wr;
   assign o_tx_byte  = acc;

   ////////////////////////////////////////////////////////////
   // branches

   always_comb begin
      case (op.full)
         c51_pkg::op_sjmp: br_cond = 1'b1;
         c51_pkg::op_jz:   br_cond = (acc == 8'd0);
         c51_pkg::op_jnz:  br_cond = (acc != 8'd0);
         c51_pkg::op_jc:   br_cond = carry;
         c51_pkg::op_jnc:  br_cond = ~carry;
         default:          br_cond = (op.rn.grp == c51_pkg::op_djnz_rn) && (r_dec != 8'd0);
      endcase
   end

   // signed offset from the next instruction
   assign o_redirect = '{taken:  i_valid & br_cond,
                         target: i_instr.next_pc + c51_pkg::pc_t'($signed(i_instr.b1))};

   ////////////////////////////////////////////////////////////
   // alu and writeback select

   always_comb begin
      acc_nxt = acc;
      acc_we  = 1'b0;
      c_nxt   = carry;
      c_we    = 1'b0;
      r_nxt   = acc;
      r_we    = 1'b0;
      dptr_we = 1'b0;
      case (op.rn.grp)
         c51_pkg::op_add_a_rn: begin
            acc_nxt = sum[7:0];
            acc_we  = 1'b1;
            c_nxt   = sum[8];
            c_we    = 1'b1;
         end
         c51_pkg::op_subb_a_rn: begin
            acc_nxt = diff[7:0];
            acc_we  = 1'b1;
            c_nxt   = diff[8];
            c_we    = 1'b1;
         end
         c51_pkg::op_mov_a_rn: begin
            acc_nxt = r_sel;
            acc_we  = 1'b1;
         end
         c51_pkg::op_mov_rn_a:   r_we = 1'b1;
         c51_pkg::op_mov_rn_imm: begin
            r_nxt = i_instr.b1;
            r_we  = 1'b1;
         end
         c51_pkg::op_djnz_rn: begin
            r_nxt = r_dec;
            r_we  = 1'b1;
         end
         default: begin
            acc_we = 1'b1;   // most single-byte forms touch a
            case (op.full)
               c51_pkg::op_mov_a_imm: acc_nxt = i_instr.b1;
               c51_pkg::op_add_a_imm: begin
                  acc_nxt = sum[7:0];
                  c_nxt   = sum[8];
                  c_we    = 1'b1;
               end
               c51_pkg::op_subb_a_imm: begin
                  acc_nxt = diff[7:0];
                  c_nxt   = diff[8];
                  c_we    = 1'b1;
               end
               c51_pkg::op_inc_a: acc_nxt = acc + 8'd1;   // carry untouched
               c51_pkg::op_dec_a: acc_nxt = acc - 8'd1;
               c51_pkg::op_cpl_a: acc_nxt = ~acc;
               c51_pkg::op_clr_a: acc_nxt = 8'd0;
               c51_pkg::op_clr_c: begin
                  acc_we = 1'b0;
                  c_nxt  = 1'b0;
                  c_we   = 1'b1;
               end
               c51_pkg::op_setb_c: begin
                  acc_we = 1'b0;
                  c_nxt  = 1'b1;
                  c_we   = 1'b1;
               end
               c51_pkg::op_mov_dptr_imm: begin
                  acc_we  = 1'b0;
                  dptr_we = 1'b1;
               end
               c51_pkg::op_movx_a_dptr: begin
                  // status reads busy, anything else reads zero
                  acc_nxt = (dptr == c51_pkg::TX_STAT_ADDR) ? {7'd0, i_tx_busy} : 8'd0;
               end
               default: acc_we = 1'b0;   // nop, jumps, movx write
            endcase
         end
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (fire) begin
         if (acc_we) acc <= acc_nxt;
         if (c_we) carry <= c_nxt;
         if (r_we) regs[op.rn.idx] <= r_nxt;
         if (dptr_we) dptr <= {i_instr.b1, i_instr.b2};   // high byte first
      end
   end

endmodule

`default_nettype wire

// File: c51_top.sv
`timescale 1ns/1ps
`default_nettype none

module c51_top #(
   parameter int CLKS_PER_BIT = 104,
   parameter int PROG_BYTES   = 512
) (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_uart_rx,
   output logic o_uart_tx
);

   c51_pkg::byte_t     rx_byte;
   logic               rx_valid;
   c51_pkg::byte_t     code_byte;
   c51_pkg::pc_t       code_addr;
   logic               loaded;
   c51_pkg::instr_t    instr;
   logic               instr_valid;
   logic               instr_ready;
   c51_pkg::redirect_t redirect;
   c51_pkg::byte_t     tx_byte;
   logic               tx_valid;
   logic               tx_ready;
   logic               tx_busy;

   ////////////////////////////////////////////////////////////
   // loader

   uart_rx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) uart_rx_i (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_rx    (i_uart_rx),
      .o_byte  (rx_byte),
      .o_valid (rx_valid)
   );

   code_store #(
      .PROG_BYTES (PROG_BYTES)
   ) code_store_i (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_wr_byte  (rx_byte),
      .i_wr_valid (rx_valid),
      .i_rd_addr  (code_addr),
      .o_rd_byte  (code_byte),
      .o_loaded   (loaded)
   );

   ////////////////////////////////////////////////////////////
   // core

   fetch_decode fetch_decode_i (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_loaded    (loaded),
      .i_code      (code_byte),
      .o_code_addr (code_addr),
      .o_instr     (instr),
      .o_valid     (instr_valid),
      .i_ready     (instr_ready),
      .i_redirect  (redirect)
   );

   execute_unit execute_unit_i (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_instr    (instr),
      .i_valid    (instr_valid),
      .o_ready    (instr_ready),
      .o_redirect (redirect),
      .o_tx_byte  (tx_byte),
      .o_tx_valid (tx_valid),
      .i_tx_ready (tx_ready),
      .i_tx_busy  (tx_busy)
   );

   // output port
   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) uart_tx_i (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_byte  (tx_byte),
      .i_valid (tx_valid),
      .o_ready (tx_ready),
      .o_busy  (tx_busy),
      .o_tx    (o_uart_tx)
   );

endmodule

`default_nettype wire

// File: tb_c51_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_c51_top;

   localparam int clks_per_bit   = 8;
   localparam int prog_bytes     = 64;
   localparam int n_exp          = 10;
   localparam int frame_cycles   = 10 * clks_per_bit;
   localparam int timeout_cycles = prog_bytes * frame_cycles
                                   + n_exp * 12 * frame_cycles + 2000;

   logic i_clk     = 1'b0;
   logic i_nrst;
   logic i_uart_rx;
   logic o_uart_tx;

   c51_pkg::byte_t prog_tbl [prog_bytes];
   string          exp_name [n_exp];
   c51_pkg::byte_t exp_val  [n_exp];

   int   errors      = 0;
   int   checks      = 0;
   int   cycles      = 0;
   int   frames_seen = 0;
   logic prog_sent   = 1'b0;   // set once the last program byte has left the driver

   c51_top #(
      .CLKS_PER_BIT (clks_per_bit),
      .PROG_BYTES   (prog_bytes)
   ) c51_top_i (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_uart_rx (i_uart_rx),
      .o_uart_tx (o_uart_tx)
   );

   always #10 i_clk = ~i_clk;   // 20 ns period

   // watchdog
   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles == timeout_cycles) begin
         $display("timeout after %0d cycles, only %0d of %0d output frames arrived",
                  cycles, frames_seen, n_exp);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // checks and serial helpers

   task automatic check_value(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %s: expected %02h, actual %02h", name, expected, actual);
      end
   endtask

   // one bit time on the rx line, changed 1 ns after the edge
   task automatic drive_bit(input logic level);
      @(posedge i_clk);
      #1;
      i_uart_rx = level;
      repeat (clks_per_bit - 1) @(posedge i_clk);
   endtask

   task automatic send_byte(input c51_pkg::byte_t data);
      drive_bit(1'b0);   // start
      for (int i = 0; i < 8; i++) begin
         drive_bit(data[i]);   // lsb first
      end
      drive_bit(1'b1);   // stop
   endtask

   task automatic load_program();
      for (int i = 0; i < prog_bytes; i++) begin
         send_byte(prog_tbl[i]);
      end
      prog_sent = 1'b1;
   endtask

   // decodes one frame from o_uart_tx, samples taken mid-bit on falling edges
   task automatic receive_byte(output logic [7:0] data);
      logic [7:0] bits;
      while (o_uart_tx !== 1'b0) @(negedge i_clk);
      if (!prog_sent) begin
         errors++;
         $display("o_uart_tx went low before the program was fully loaded");
      end
      repeat (clks_per_bit / 2) @(negedge i_clk);
      if (o_uart_tx !== 1'b0) begin
         errors++;
         $display("start bit of output frame %0d did not stay low", frames_seen);
      end
      for (int i = 0; i < 8; i++) begin
         repeat (clks_per_bit) @(negedge i_clk);
         bits[i] = o_uart_tx;
      end
      repeat (clks_per_bit) @(negedge i_clk);
      if (o_uart_tx !== 1'b1) begin
         errors++;
         $display("stop bit of output frame %0d was not high", frames_seen);
      end
      data = bits;
      frames_seen++;
   endtask

   // line must stay idle once the expected frames are done
   task automatic check_quiet(input int n_cycles);
      int low_cnt;
      low_cnt = 0;
      repeat (n_cycles) begin
         @(negedge i_clk);
         if (o_uart_tx !== 1'b1) low_cnt++;
      end
      if (low_cnt != 0) begin
         errors++;
         $display("o_uart_tx left idle after the last expected frame, an extra frame was sent");
      end
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      logic [7:0] got;
      i_nrst    = 1'b0;
      i_uart_rx = 1'b1;   // serial idle

      prog_tbl = '{
         8'h90, 8'h02, 8'h01,   // 00 mov dptr,#0201
         8'h74, 8'h25,          // 03 mov a,#25
         8'h24, 8'h13,          // 05 add a,#13  -> 38
         8'hF0,                 // 07 send
         8'h24, 8'hD8,          // 08 add a,#d8  -> 10, c set
         8'h40, 8'h01,          // 0a jc +1
         8'hE4,                 // 0c clr a, skipped
         8'hF0,                 // 0d send
         8'h94, 8'h05,          // 0e subb a,#05 -> 0a
         8'hF0,                 // 10 send
         8'h14,                 // 11 dec a      -> 09
         8'hF4,                 // 12 cpl a      -> f6
         8'hF0,                 // 13 send
         8'hE4,                 // 14 clr a
         8'h7B, 8'h05,          // 15 mov r3,#05
         8'h04,                 // 17 inc a
         8'hDB, 8'hFD,          // 18 djnz r3,17
         8'hF0,                 // 1a send 05
         8'h7A, 8'h11,          // 1b mov r2,#11
         8'hEA,                 // 1d mov a,r2
         8'hF0,                 // 1e send
         8'h2A,                 // 1f add a,r2   -> 22
         8'hF0,                 // 20 send
         8'hF0,                 // 21 send again, back to back
         8'h80, 8'h01,          // 22 sjmp +1
         8'hF0,                 // 24 skipped send
         8'h90, 8'h02, 8'h00,   // 25 mov dptr,#0200
         8'hF0,                 // 28 write to status, no frame
         8'hE0,                 // 29 read busy  -> 1
         8'hFE,                 // 2a mov r6,a
         8'h7F, 8'h28,          // 2b mov r7,#40
         8'hDF, 8'hFE,          // 2d djnz r7,2d
         8'hE0,                 // 2f read busy  -> 0
         8'h90, 8'h02, 8'h01,   // 30 mov dptr,#0201
         8'hF0,                 // 33 send 00
         8'h60, 8'h01,          // 34 jz +1, taken
         8'h14,                 // 36 dec a, skipped
         8'h70, 8'h01,          // 37 jnz +1, not taken
         8'h2E,                 // 39 add a,r6   -> 01
         8'h60, 8'h01,          // 3a jz +1, not taken
         8'hF0,                 // 3c send 01
         8'h70, 8'hFE,          // 3d jnz to itself, halt
         8'hF0                  // 3f only reached if the jnz fails
      };

      exp_name = '{"add_imm", "jc_taken", "subb_carry_in", "dec_cpl", "djnz_count",
                   "mov_a_rn", "add_a_rn", "back_to_back", "stat_idle", "stat_busy"};
      exp_val  = '{8'h38, 8'h10, 8'h0A, 8'hF6, 8'h05,
                   8'h11, 8'h22, 8'h22, 8'h00, 8'h01};

      // reset held for 5 cycles
      repeat (4) @(posedge i_clk);
      @(negedge i_clk);
      check_value("tx_idle_in_reset", 8'h01, {7'd0, o_uart_tx});
      @(posedge i_clk);
      #1;
      i_nrst = 1'b1;

      fork
         load_program();
         begin
            for (int i = 0; i < n_exp; i++) begin
               receive_byte(got);
               check_value(exp_name[i], exp_val[i], got);
            end
         end
      join

      check_quiet(3 * frame_cycles);

      $display("checks %0d, errors %0d, frames %0d", checks, errors, frames_seen);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
c51_pkg.sv
uart_rx.sv
uart_tx.sv
code_store.sv
fetch_decode.sv
execute_unit.sv
c51_top.sv
tb_c51_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_c51_top \
   && ./obj_dir/Vtb_c51_top | tee /dev/stderr | grep -q "RESULT: PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
